//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = sm83CoreTb
FILELIST = list.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- list.f
+incdir+src
src/sm83Pkg.sv
src/sm83Decode.sv
src/sm83Alu.sv
src/sm83RegFile.sv
src/sm83Sequencer.sv
src/sm83Core.sv
test/sm83CoreTb.sv

//--- src/sm83Alu.sv
`timescale 1ns/1ps
`default_nettype none

module sm83Alu import sm83Pkg::*; (
	input  wire [7:0] a,       // Accumulator
	input  wire [7:0] operand, // Register or immediate
	input  wire flags_t flagsIn,
	input  wire aluOp_e aluOp,
	output aluResult_t res
);

	logic       carryIn; // Carry or borrow in for ADC/SBC
	logic [8:0] addFull; // Bit 8 is carry out of bit 7
	logic [4:0] addHalf; // Bit 4 is carry out of bit 3
	logic [8:0] subFull; // Bit 8 is borrow
	logic [4:0] subHalf; // Bit 4 is borrow from bit 4

	assign carryIn = (aluOp == opAdc || aluOp == opSbc) ? flagsIn.c : 1'b0;

	// Both paths always computed, op picks one
	always_comb begin
		addFull = {1'b0, a} + {1'b0, operand} + {8'd0, carryIn};
		addHalf = {1'b0, a[3:0]} + {1'b0, operand[3:0]} + {4'd0, carryIn};
		subFull = {1'b0, a} - {1'b0, operand} - {8'd0, carryIn};
		subHalf = {1'b0, a[3:0]} - {1'b0, operand[3:0]} - {4'd0, carryIn};
	end

	always_comb begin
		res.value   = 8'h00;
		res.flags   = '0;
		res.writeA  = (aluOp != opCp); // CP only sets flags

		case (aluOp)
			opAdd, opAdc: begin
				res.value   = addFull[7:0];
				res.flags.n = 1'b0;
				res.flags.h = addHalf[4];
				res.flags.c = addFull[8];
			end
			opSub, opSbc, opCp: begin
				res.value   = subFull[7:0]; // CP result feeds Z only
				res.flags.n = 1'b1;
				res.flags.h = subHalf[4];
				res.flags.c = subFull[8];
			end
			opAnd: begin
				res.value   = a & operand;
				res.flags.h = 1'b1; // SM83 quirk, H set on AND
			end
			opXor: begin
				res.value = a ^ operand;
			end
			opOr: begin
				res.value = a | operand;
			end
			default: begin
				res.value = a;
			end
		endcase

		res.flags.z = (res.value == 8'h00);
	end

endmodule

`default_nettype wire

//--- src/sm83Core.sv
`timescale 1ns/1ps
`default_nettype none

module sm83Core import sm83Pkg::*; (
	input  wire         CLK,
	input  wire         rstN,
	input  wire [7:0]   dataIn,  // Memory read data
	output logic [15:0] addr,
	output logic [7:0]  dataOut, // Memory write data
	output logic        rd,
	output logic        wr,
	output logic        m1,      // Opcode fetch cycle
	output logic        clkEna   // Low once halted
);

	logic [7:0]  ir;
	logic [7:0]  imm;
	logic [7:0]  operand;
	logic [7:0]  regA;
	logic [15:0] hl;
	logic        commit;
	decodedOp_t  op;
	aluResult_t  aluRes;
	flags_t      flags;

	sm83Sequencer sm83Sequencer_inst (
		.CLK     (CLK),
		.rstN    (rstN),
		.op      (op),
		.dataIn  (dataIn),
		.operand (operand),
		.regA    (regA),
		.flags   (flags),
		.hl      (hl),
		.ir      (ir),
		.imm     (imm),
		.commit  (commit),
		.addr    (addr),
		.dataOut (dataOut),
		.rd      (rd),
		.wr      (wr),
		.m1      (m1),
		.clkEna  (clkEna)
	);

	sm83Decode sm83Decode_inst (
		.ir (ir),
		.op (op)
	);

	sm83Alu sm83Alu_inst (
		.a       (regA),
		.operand (operand),
		.flagsIn (flags),   // Carry in for ADC/SBC
		.aluOp   (op.aluOp),
		.res     (aluRes)
	);

	sm83RegFile sm83RegFile_inst (
		.CLK     (CLK),
		.rstN    (rstN),
		.commit  (commit),
		.op      (op),
		.imm     (imm),
		.aluRes  (aluRes),
		.operand (operand),
		.regA    (regA),
		.flags   (flags),
		.hl      (hl)
	);

endmodule

`default_nettype wire

//--- src/sm83Decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_defs.svh"

module sm83Decode import sm83Pkg::*; (
	input  wire [7:0] ir, // Latched opcode
	output decodedOp_t op
);

	logic [1:0] grp; // Opcode bits 7:6
	logic [2:0] yFld; // Opcode bits 5:3
	logic [2:0] zFld; // Opcode bits 2:0

	assign grp  = ir[7:6];
	assign yFld = ir[5:3];
	assign zFld = ir[2:0];

	always_comb begin
		// Field defaults, kind decides which ones matter
		op.kind    = kIllegal;
		op.aluOp   = aluOp_e'(yFld);
		op.srcReg  = regSel_e'(zFld);
		op.dstReg  = regSel_e'(yFld);
		op.mCycles = `MC_SHORT;

		if (ir == 8'h00) begin
			op.kind = kNop;
		end else if (grp == 2'b00 && zFld == 3'b110) begin
			if (yFld != rMem) begin // LD (HL),n8 not supported
				op.kind    = kLdImm;
				op.mCycles = `MC_IMM;
			end
		end else if (ir == 8'h76) begin // Sits inside the LD (HL),r block
			op.kind = kHalt;
		end else if (ir[7:3] == 5'b01110) begin
			if (zFld != rMem) begin
				op.kind    = kStHl;
				op.mCycles = `MC_STORE;
			end
		end else if (grp == 2'b10) begin
			if (zFld != rMem) begin // ALU A,(HL) not supported
				op.kind   = kAluReg;
				op.dstReg = rA;
			end
		end else if (grp == 2'b11 && zFld == 3'b110) begin
			op.kind    = kAluImm;
			op.dstReg  = rA;
			op.mCycles = `MC_IMM;
		end else if (ir == 8'hF5) begin
			op.kind    = kPushAf;
			op.srcReg  = rA;
			op.mCycles = `MC_PUSH;
		end

		// Undecoded opcodes fall through as one-cycle kIllegal
	end

endmodule

`default_nettype wire

//--- src/sm83Pkg.sv
`default_nettype none

package sm83Pkg;

	// Instruction classes seen by the sequencer
	typedef enum logic [2:0] {
		kNop,
		kLdImm,    // LD r,n8
		kStHl,     // LD (HL),r
		kAluReg,   // ALU A,r
		kAluImm,   // ALU A,n8
		kPushAf,
		kHalt,
		kIllegal   // Runs as NOP
	} instrKind_e;

	// Same order as opcode bits 5:3
	typedef enum logic [2:0] {
		opAdd,
		opAdc,
		opSub,
		opSbc,
		opAnd,
		opXor,
		opOr,
		opCp
	} aluOp_e;

	// Register field encoding, rMem stands for (HL)
	typedef enum logic [2:0] {
		rB, rC, rD, rE, rH, rL, rMem, rA
	} regSel_e;

	// Upper nibble of F
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

	typedef struct packed {
		instrKind_e kind;
		aluOp_e     aluOp;
		regSel_e    srcReg;  // ALU or store source
		regSel_e    dstReg;  // LD r,n8 target
		logic [2:0] mCycles; // Machine cycles incl. fetch
	} decodedOp_t;

	typedef struct packed {
		logic [7:0] value;
		flags_t     flags;
		logic       writeA; // Low for CP
	} aluResult_t;

endpackage

`default_nettype wire

//--- src/sm83RegFile.sv
`timescale 1ns/1ps
`default_nettype none

module sm83RegFile import sm83Pkg::*; (
	input  wire        CLK,
	input  wire        rstN,
	input  wire        commit, // Final T3 of the instruction
	input  wire decodedOp_t op,
	input  wire [7:0]  imm,    // Latched immediate byte
	input  wire aluResult_t aluRes,
	output logic [7:0] operand, // ALU source or store data
	output logic [7:0] regA,
	output flags_t     flags,
	output logic [15:0] hl     // Store address
);

	logic [7:0] regs [0:7]; // Indexed by regSel_e, slot rMem stays zero
	flags_t     flagsQ;

	assign regA  = regs[rA];
	assign hl    = {regs[rH], regs[rL]};
	assign flags = flagsQ;

	// Immediate only for ALU A,n8
	assign operand = (op.kind == kAluImm) ? imm : regs[op.srcReg];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 8'h00;
			end
			flagsQ <= '0;
		end else if (commit) begin
			case (op.kind)
				kLdImm: begin
					regs[op.dstReg] <= imm;
				end
				kAluReg, kAluImm: begin
					if (aluRes.writeA) begin // Skipped for CP
						regs[rA] <= aluRes.value;
					end
					flagsQ <= aluRes.flags;
				end
				default: begin
					// Nothing to write back
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/sm83Sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_defs.svh"

module sm83Sequencer import sm83Pkg::*; (
	input  wire         CLK,
	input  wire         rstN,
	input  wire decodedOp_t op,
	input  wire [7:0]   dataIn,
	input  wire [7:0]   operand, // Store data for LD (HL),r
	input  wire [7:0]   regA,
	input  wire flags_t flags,
	input  wire [15:0]  hl,
	output logic [7:0]  ir,
	output logic [7:0]  imm,
	output logic        commit,  // One clock at final T3
	output logic [15:0] addr,
	output logic [7:0]  dataOut,
	output logic        rd,
	output logic        wr,
	output logic        m1,
	output logic        clkEna
);

	typedef enum logic [1:0] {bcIdle, bcFetch, bcRead, bcWrite} busCycle_e;
	typedef enum logic [1:0] {srcPc, srcHl, srcSp} addrSrc_e;

	logic [1:0]  tState;  // T0..T3
	logic [1:0]  mCycle;  // Machine cycle within instruction
	logic [15:0] pc;
	logic [15:0] sp;
	logic        started; // Set on first clock after reset
	logic        halted;
	logic        live;
	logic        lastT;   // T3
	logic        sampleT; // T2, read data sampled at its end
	logic        lastM;   // Final machine cycle of op
	busCycle_e   cycle;
	addrSrc_e    addrSrc;

	assign live    = started & ~halted;
	assign lastT   = (tState == 2'(`T_STATES - 1));
	assign sampleT = (tState == 2'(`T_STATES - 2));
	assign lastM   = ({1'b0, mCycle} == op.mCycles - 3'd1); // op valid from fetch T3
	assign commit  = live & lastT & lastM;

	// Cycle type and address source from op.kind and mCycle
	always_comb begin
		cycle   = bcIdle;
		addrSrc = srcSp;
		dataOut = operand;
		if (mCycle == 2'd0) begin
			cycle   = bcFetch;
			addrSrc = srcPc;
		end else begin
			case (op.kind)
				kLdImm, kAluImm: begin
					cycle   = bcRead; // Immediate at PC
					addrSrc = srcPc;
				end
				kStHl: begin
					cycle   = bcWrite;
					addrSrc = srcHl;
				end
				kPushAf: begin
					if (mCycle == 2'd2) begin // SP already at SP-1
						cycle   = bcWrite;
						dataOut = regA;
					end else if (mCycle == 2'd3) begin
						cycle   = bcWrite;
						dataOut = {flags, 4'h0}; // F low nibble reads zero
					end
				end
				default: begin
					cycle = bcIdle;
				end
			endcase
		end
	end

	always_comb begin
		case (addrSrc)
			srcPc:   addr = pc;
			srcHl:   addr = hl;
			default: addr = sp; // Also idle cycle of PUSH
		endcase
	end

	assign rd     = live & (cycle == bcFetch || cycle == bcRead) & ~lastT;
	assign wr     = live & (cycle == bcWrite) & (tState == 2'd1 || tState == 2'd2);
	assign m1     = live & (cycle == bcFetch);
	assign clkEna = ~halted;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			tState  <= 2'd0;
			mCycle  <= 2'd0;
			pc      <= `RESET_PC;
			sp      <= `RESET_SP;
			ir      <= 8'h00; // NOP until first fetch
			started <= 1'b0;
			halted  <= 1'b0;
		end else if (!started) begin
			started <= 1'b1;
		end else if (!halted) begin
			tState <= tState + 2'd1;
			if (sampleT && cycle == bcFetch) begin
				ir <= dataIn;
			end
			if (lastT) begin
				if (cycle == bcFetch || cycle == bcRead) begin
					pc <= pc + 16'd1; // Held until T3 so addr stays put
				end
				if (op.kind == kPushAf && (mCycle == 2'd1 || mCycle == 2'd2)) begin
					sp <= sp - 16'd1;
				end
				mCycle <= lastM ? 2'd0 : mCycle + 2'd1;
				if (lastM && op.kind == kHalt) begin
					halted <= 1'b1; // Stops counters, drops clkEna
				end
			end
		end
	end

	// Immediate byte from the non-fetch read cycle
	always_ff @(posedge CLK) begin
		if (live && sampleT && cycle == bcRead) begin
			imm <= dataIn;
		end
	end

endmodule

`default_nettype wire

//--- src/sm83_defs.svh
`ifndef SM83_DEFS_SVH
`define SM83_DEFS_SVH

// Register values loaded by reset
`define RESET_PC 16'h0000 // First opcode fetch address
`define RESET_SP 16'hFFFE // Top of stack

// Bus timing
`define T_STATES 4 // Clocks per machine cycle

// Machine cycles per instruction class
`define MC_SHORT 3'd1 // NOP, ALU r, HALT, undecoded
`define MC_IMM   3'd2 // Opcode plus immediate fetch
`define MC_STORE 3'd2 // Opcode plus write to (HL)
`define MC_PUSH  3'd4 // Opcode, internal, two writes

`endif

//--- test/sm83CoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_defs.svh"

module sm83CoreTb import sm83Pkg::*; ();

	typedef struct packed {
		instrKind_e kind;
		aluOp_e     aluOp;
		regSel_e    src;
		regSel_e    dst;
		logic [7:0] imm;
	} stimEntry_t;

	logic        CLK;
	logic        rstN;
	logic [7:0]  dataIn = 8'h00;
	logic [15:0] addr;
	logic [7:0]  dataOut;
	logic        rd, wr, m1, clkEna;

	logic [7:0]  mem [0:255];     // Program memory indexed by addr[7:0]
	stimEntry_t  tbl[$];
	logic [31:0] expFetch[$];     // {pc, clocks since previous m1}
	logic [23:0] expWr[$];        // {addr, data}
	integer      seed = 11963;
	int          totalMc, limit, cycles, lastFetch, checks;
	int          busErrors, flowErrors;
	logic        rdPrev, wrPrev, clkEnaPrev;

	sm83Core sm83Core_inst (.CLK(CLK), .rstN(rstN), .dataIn(dataIn), .addr(addr),
		.dataOut(dataOut), .rd(rd), .wr(wr), .m1(m1), .clkEna(clkEna));

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK; // 8 ns period
	end

	always @(posedge CLK) begin
		if (!rstN) cycles <= 0;
		else cycles <= cycles + 1;
	end

	function automatic logic [7:0] nextRand();
		integer r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Flag rules of the SM83 for the eight ALU ops
	function automatic aluResult_t aluModel(input aluOp_e o, input logic [7:0] a,
		input logic [7:0] b, input flags_t f);
		aluResult_t r;
		int         cin;
		int         full;
		cin = ((o == opAdc || o == opSbc) && f.c) ? 1 : 0;
		r = '0;
		r.writeA = 1'b1;
		case (o)
			opAdd, opAdc: begin
				full = int'(a) + int'(b) + cin;
				r.flags.h = (int'(a[3:0]) + int'(b[3:0]) + cin) > 15; // Carry out of bit 3
				r.flags.c = full > 255;
			end
			opSub, opSbc, opCp: begin
				full = int'(a) - int'(b) - cin;
				r.flags.n = 1'b1;
				r.flags.h = int'(a[3:0]) < int'(b[3:0]) + cin; // Borrow from bit 4
				r.flags.c = full < 0;
				r.writeA = (o != opCp);
			end
			opAnd: begin
				full = int'(a & b);
				r.flags.h = 1'b1;
			end
			opXor: full = int'(a ^ b);
			default: full = int'(a | b);
		endcase
		r.value = 8'(full);
		r.flags.z = (r.value == 8'h00);
		return r;
	endfunction

	task automatic addEntry(input instrKind_e k, input aluOp_e o, input regSel_e s,
		input regSel_e d, input logic [7:0] imm);
		tbl.push_back({k, o, s, d, imm});
	endtask

	task automatic loadTable();
		addEntry(kLdImm, opAdd, rB, rH, 8'h80);
		addEntry(kLdImm, opAdd, rB, rL, nextRand());
		addEntry(kLdImm, opAdd, rB, rB, 8'h0F);
		addEntry(kLdImm, opAdd, rB, rC, 8'hFF);
		addEntry(kLdImm, opAdd, rB, rD, nextRand());
		addEntry(kLdImm, opAdd, rB, rE, nextRand());
		addEntry(kAluReg, opAdd, rC, rA, 8'h00); // A starts at zero
		addEntry(kAluImm, opAdd, rB, rA, 8'h0F); // Half and full carry
		addEntry(kAluReg, opAdc, rB, rA, 8'h00);
		addEntry(kAluImm, opAdc, rB, rA, 8'h00);
		addEntry(kPushAf, opAdd, rA, rA, 8'h00);
		addEntry(kAluReg, opSub, rD, rA, 8'h00);
		addEntry(kAluImm, opSub, rB, rA, 8'h80);
		addEntry(kAluReg, opSbc, rE, rA, 8'h00);
		addEntry(kAluImm, opSbc, rB, rA, nextRand());
		addEntry(kStHl, opAdd, rA, rA, 8'h00);
		addEntry(kAluReg, opAnd, rL, rA, 8'h00);
		addEntry(kAluImm, opAnd, rB, rA, nextRand());
		addEntry(kPushAf, opAdd, rA, rA, 8'h00); // SP keeps falling on second push
		addEntry(kAluReg, opXor, rC, rA, 8'h00);
		addEntry(kAluImm, opXor, rB, rA, nextRand());
		addEntry(kAluReg, opOr, rH, rA, 8'h00);
		addEntry(kNop, opAdd, rB, rB, 8'h00);
		addEntry(kAluImm, opOr, rB, rA, 8'h00);
		addEntry(kStHl, opAdd, rB, rB, 8'h00);
		addEntry(kAluReg, opCp, rE, rA, 8'h00);
		addEntry(kAluImm, opCp, rB, rA, nextRand());
		addEntry(kPushAf, opAdd, rA, rA, 8'h00);
		addEntry(kStHl, opAdd, rA, rA, 8'h00); // A must survive both CPs
		addEntry(kHalt, opAdd, rB, rB, 8'h00);
	endtask

	// Assemble into mem and run the reference model alongside
	task automatic buildProgram();
		logic [15:0] pc;
		logic [15:0] sp;
		logic [7:0]  regs [0:7];
		logic [7:0]  b;
		flags_t      fl;
		aluResult_t  r;
		stimEntry_t  s;
		int          mc;
		int          prevMc;
		pc = `RESET_PC;
		sp = `RESET_SP;
		fl = '0;
		prevMc = 0;
		totalMc = 0;
		for (int i = 0; i < 8; i++) regs[i] = 8'h00;
		for (int i = 0; i < 256; i++) mem[i] = 8'h00;
		loadTable();
		foreach (tbl[i]) begin
			s = tbl[i];
			mc = 1;
			expFetch.push_back({pc, 16'(prevMc * `T_STATES)});
			case (s.kind)
				kLdImm: begin
					mem[pc[7:0]] = {2'b00, s.dst, 3'b110};
					mem[pc[7:0] + 8'd1] = s.imm;
					regs[s.dst] = s.imm;
					mc = 2;
				end
				kStHl: begin
					mem[pc[7:0]] = {5'b01110, s.src};
					expWr.push_back({regs[rH], regs[rL], regs[s.src]});
					mc = 2;
				end
				kAluReg, kAluImm: begin
					if (s.kind == kAluImm) begin
						mem[pc[7:0]] = {2'b11, s.aluOp, 3'b110};
						mem[pc[7:0] + 8'd1] = s.imm;
						b = s.imm;
						mc = 2;
					end else begin
						mem[pc[7:0]] = {2'b10, s.aluOp, s.src};
						b = regs[s.src];
					end
					r = aluModel(s.aluOp, regs[rA], b, fl);
					if (r.writeA) regs[rA] = r.value;
					fl = r.flags;
				end
				kPushAf: begin
					mem[pc[7:0]] = 8'hF5;
					expWr.push_back({16'(sp - 16'd1), regs[rA]});
					expWr.push_back({16'(sp - 16'd2), fl, 4'h0}); // F low nibble zero
					sp = sp - 16'd2;
					mc = 4;
				end
				kHalt: mem[pc[7:0]] = 8'h76;
				default: mem[pc[7:0]] = 8'h00;
			endcase
			pc = pc + ((mc == 2 && s.kind != kStHl) ? 16'd2 : 16'd1);
			prevMc = mc;
			totalMc += mc;
		end
	endtask

	task automatic checkFetch();
		logic [31:0] e;
		if (expFetch.size() == 0) begin
			busErrors++;
			$display("Unexpected opcode fetch at address %h", addr);
		end else begin
			e = expFetch.pop_front();
			checks++;
			if (addr !== e[31:16]) begin
				busErrors++;
				$display("ERR m1 addr exp %h got %h", e[31:16], addr);
			end
			if (e[15:0] != 16'd0 && (cycles - lastFetch) != 32'(e[15:0])) begin
				busErrors++;
				$display("ERR m1 gap exp %h got %h", e[15:0], cycles - lastFetch);
			end
		end
		lastFetch = cycles;
	endtask

	task automatic checkWrite();
		logic [23:0] e;
		if (expWr.size() == 0) begin
			busErrors++;
			$display("Unexpected write to address %h", addr);
		end else begin
			e = expWr.pop_front();
			checks++;
			if (addr !== e[23:8]) begin
				busErrors++;
				$display("ERR addr exp %h got %h", e[23:8], addr);
			end
			if (dataOut !== e[7:0]) begin
				busErrors++;
				$display("ERR dataOut exp %h got %h", e[7:0], dataOut);
			end
		end
	endtask

	// Memory model and bus monitor on the falling edge
	always @(negedge CLK) begin
		if (rd) dataIn <= mem[addr[7:0]];
		if (rstN) begin
			// m1 stays high across back-to-back fetches, rd restarts each one
			if (m1 && rd && !rdPrev) checkFetch();
			if (wr && !wrPrev) checkWrite();
			if (!clkEna && clkEnaPrev && (cycles - lastFetch) != `T_STATES) begin
				busErrors++;
				$display("ERR clkEna fall exp %h got %h", `T_STATES, cycles - lastFetch);
			end
			if (!clkEna && (rd || wr)) begin
				busErrors++;
				$display("Bus cycle started after the core halted");
			end
		end
		rdPrev = rd;
		wrPrev = wr;
		clkEnaPrev = clkEna;
	end

	task automatic checkResetIdle();
		if (rd !== 1'b0 || wr !== 1'b0 || m1 !== 1'b0 || clkEna !== 1'b1) begin
			flowErrors++;
			$display("Bus outputs not idle during reset");
		end
	endtask

	initial begin
		rstN = 1'b0;
		checks = 0;
		busErrors = 0;
		flowErrors = 0;
		lastFetch = 0;
		buildProgram();
		limit = (totalMc + 20) * `T_STATES;
		repeat (10) begin
			@(negedge CLK);
			checkResetIdle();
		end
		rstN = 1'b1;
		while (clkEna === 1'b1 && cycles < limit) @(negedge CLK);
		if (clkEna === 1'b1) begin
			flowErrors++;
			$display("Timeout, core did not halt within %0d cycles", limit);
		end
		repeat (2 * `T_STATES) @(negedge CLK); // Watch for bus activity after halt
		if (expFetch.size() != 0) begin
			flowErrors++;
			$display("%0d expected opcode fetches never happened", expFetch.size());
		end
		if (expWr.size() != 0) begin
			flowErrors++;
			$display("%0d expected writes never happened", expWr.size());
		end
		$display("Checks %0d, bus errors %0d, flow errors %0d", checks, busErrors, flowErrors);
		if (busErrors == 0 && flowErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
